//--- src.f
design/analog_pkg.sv
design/adc_capture.sv
design/analog_channel.sv
design/dac_output.sv
design/analog_top.sv
verif/tb_analog_top.sv

//--- verif/tb_analog_top.sv
/*
 * directed testbench for the analog data path top level
 * reference model functions, reset, ADC, DAC, saturation and loopback tests
 */

`timescale 1ns/10ps

module tb_analog_top;

  //////////////////////////////////////////////////
  // constants and types
  //////////////////////////////////////////////////

  localparam int NCH = 2;
  localparam int W   = analog_pkg::SAMPLE_W;

  typedef analog_pkg::sample_t  [NCH-1:0] smp_vec_t;  // one word per channel
  typedef analog_pkg::dac_src_t [NCH-1:0] src_vec_t;  // one source pair per channel

  //////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////

  logic     adc_clk = 1'b0;
  logic     rst_n;
  smp_vec_t adc_dat;
  src_vec_t dac_src;
  logic     digital_loop;
  smp_vec_t scope_dat;
  smp_vec_t dac_dat;
  logic     dac_reset;

  int       err_count;    // failed checks
  int       check_count;  // all checks done
  src_vec_t src_list[$];  // source vectors for the DAC stream

  analog_top #(
    .NCH (NCH)
  ) UUT (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n       ),
    .adc_dat_i      (adc_dat     ),
    .dac_src_i      (dac_src     ),
    .digital_loop_i (digital_loop),
    .scope_dat_o    (scope_dat   ),
    .dac_dat_o      (dac_dat     ),
    .dac_reset_o    (dac_reset   )
  );

  always #2 adc_clk = ~adc_clk;  // 4 ns period

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // ADC word with its noisy low bits forced to zero
  function automatic analog_pkg::sample_t clear_adc_lsbs(analog_pkg::sample_t raw);
    analog_pkg::sample_t mask;
    mask = '1;
    mask = mask << analog_pkg::ADC_DROP;  // zeros in the dropped bits
    return raw & mask;
  endfunction

  // add, clamp to the signed sample range, flip every bit
  function automatic analog_pkg::sample_t dac_code_of(analog_pkg::sample_t asg,
                                                      analog_pkg::sample_t pid);
    int         total;
    int         hi;
    int         lo;
    logic [W-1:0] bits;
    hi    = (1 << (W - 1)) - 1;  // 8191
    lo    = -(1 << (W - 1));     // -8192
    total = int'(asg) + int'(pid);
    if (total > hi)
    begin
      total = hi;
    end
    else if (total < lo)
    begin
      total = lo;
    end
    bits = total[W-1:0];
    return ~bits;  // negative slope DAC
  endfunction

  // any 14 bit pattern
  function automatic analog_pkg::sample_t rand_sample();
    return W'($urandom);
  endfunction

  // half range, so two of them never overflow
  function automatic analog_pkg::sample_t rand_small_sample();
    int half;
    int v;
    half = 1 << (W - 2);
    v    = int'($urandom % (2 * half)) - half;
    return W'(v);
  endfunction

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic check_outputs_zero();
    for (int k = 0; k < NCH; k++)
    begin
      check_count++;
      if (scope_dat[k] !== '0)
      begin
        $display("CHECK FAILED scope_dat_o[%0d] expected %h got %h", k, 14'h0, scope_dat[k]);
        err_count++;
      end
      check_count++;
      if (dac_dat[k] !== '0)
      begin
        $display("CHECK FAILED dac_dat_o[%0d] expected %h got %h", k, 14'h0, dac_dat[k]);
        err_count++;
      end
    end
  endtask

  // 8 edges in reset, then watch dac_reset_o fall
  task automatic reset_test();
    int edges;
    for (int c = 1; c <= 8; c++)
    begin
      @(posedge adc_clk);
      if (c == 8)
      begin
        rst_n <= 1'b1;  // next edge is the first one to see it high
      end
      @(negedge adc_clk);
      check_count++;
      if (dac_reset !== 1'b1)
      begin
        $display("CHECK FAILED dac_reset_o expected %h got %h", 1'b1, dac_reset);
        err_count++;
      end
      check_outputs_zero();
    end
    edges = 0;
    while (dac_reset !== 1'b0 && edges < 16)  // bounded wait
    begin
      @(posedge adc_clk);
      @(negedge adc_clk);
      edges++;
    end
    if (dac_reset !== 1'b0)
    begin
      $display("dac_reset_o stayed high long after reset was released");
      err_count++;
    end
    else if (edges != 1)
    begin
      $display("CHECK FAILED dac_reset_o release edge expected %h got %h", 1, edges);
      err_count++;
    end
    check_outputs_zero();  // first cycle out of reset
  endtask

  // raw ADC words to scope_dat_o, 2 cycles, channels crossed
  task automatic adc_path_test(input int n);
    smp_vec_t exp_q[$];
    smp_vec_t raw;
    smp_vec_t exp;
    for (int i = 0; i < n + 2; i++)
    begin
      @(posedge adc_clk);
      if (i < n)
      begin
        for (int k = 0; k < NCH; k++)
        begin
          raw[k] = rand_sample();
        end
        adc_dat      <= raw;
        digital_loop <= 1'b0;
        for (int k = 0; k < NCH; k++)
        begin
          exp[k] = clear_adc_lsbs(raw[NCH-1-k]);  // element k reads pad NCH-1-k
        end
        exp_q.push_back(exp);
      end
      @(negedge adc_clk);
      if (i >= 2)
      begin
        exp = exp_q.pop_front();
        for (int k = 0; k < NCH; k++)
        begin
          check_count++;
          if (scope_dat[k] !== exp[k])
          begin
            $display("CHECK FAILED scope_dat_o[%0d] expected %h got %h", k, exp[k], scope_dat[k]);
            err_count++;
          end
        end
      end
    end
  endtask

  // stream src_list through, dac_dat_o 2 cycles later
  task automatic apply_dac_list();
    smp_vec_t exp_q[$];
    smp_vec_t exp;
    src_vec_t src;
    int       n;
    n = src_list.size();
    for (int i = 0; i < n + 2; i++)
    begin
      @(posedge adc_clk);
      if (i < n)
      begin
        src = src_list[i];
        dac_src <= src;
        for (int k = 0; k < NCH; k++)
        begin
          exp[k] = dac_code_of(src[NCH-1-k].asg, src[NCH-1-k].pid);  // pins crossed
        end
        exp_q.push_back(exp);
      end
      @(negedge adc_clk);
      if (i >= 2)
      begin
        exp = exp_q.pop_front();
        for (int k = 0; k < NCH; k++)
        begin
          check_count++;
          if (dac_dat[k] !== exp[k])
          begin
            $display("CHECK FAILED dac_dat_o[%0d] expected %h got %h", k, exp[k], dac_dat[k]);
            err_count++;
          end
        end
      end
    end
    src_list.delete();
  endtask

  task automatic dac_path_test(input int n);
    src_vec_t src;
    for (int i = 0; i < n; i++)
    begin
      for (int k = 0; k < NCH; k++)
      begin
        src[k].asg = rand_small_sample();
        src[k].pid = rand_small_sample();
      end
      src_list.push_back(src);
    end
    apply_dac_list();
  endtask

  // edges of the clamp, both signs
  task automatic saturation_test();
    int       asg_tab[8] = '{8191, -8192, 8191, -8192, 8191, -8192, 4096, -4096};
    int       pid_tab[8] = '{1, -1, 8191, -8192, 0, 0, 4096, -4097};
    src_vec_t src;
    for (int j = 0; j < 8; j += NCH)
    begin
      for (int k = 0; k < NCH; k++)
      begin
        src[k].asg = W'(asg_tab[(j + k) % 8]);
        src[k].pid = W'(pid_tab[(j + k) % 8]);
      end
      src_list.push_back(src);
    end
    apply_dac_list();
  endtask

  // scope shows each channel's own code, 1 cycle, ADC ignored
  task automatic loopback_test(input int n);
    smp_vec_t exp_q[$];
    smp_vec_t raw;
    smp_vec_t exp;
    src_vec_t src;
    for (int i = 0; i < n + 1; i++)
    begin
      @(posedge adc_clk);
      if (i < n)
      begin
        for (int k = 0; k < NCH; k++)
        begin
          src[k].asg = rand_sample();  // full range, overflow allowed
          src[k].pid = rand_sample();
          raw[k]     = rand_sample();
          exp[k]     = dac_code_of(src[k].asg, src[k].pid);  // no crossing here
        end
        adc_dat      <= raw;
        dac_src      <= src;
        digital_loop <= 1'b1;
        exp_q.push_back(exp);
      end
      @(negedge adc_clk);
      if (i >= 1)
      begin
        exp = exp_q.pop_front();
        for (int k = 0; k < NCH; k++)
        begin
          check_count++;
          if (scope_dat[k] !== exp[k])
          begin
            $display("CHECK FAILED scope_dat_o[%0d] expected %h got %h", k, exp[k], scope_dat[k]);
            err_count++;
          end
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'h8834));
    err_count    = 0;
    check_count  = 0;
    rst_n        = 1'b0;
    adc_dat      = '1;  // pads busy while in reset
    dac_src      = '0;
    digital_loop = 1'b0;

    reset_test();
    adc_path_test(50);
    dac_path_test(50);
    saturation_test();
    loopback_test(20);
    adc_path_test(8);  // loop cleared, ADC back within 2 cycles

    $display("checks: %0d  errors: %0d", check_count, err_count);
    if (err_count == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : tb_analog_top

//--- design/analog_top.sv
/*
 * analog data path top level
 * ADC capture, per-channel sum and loopback, DAC output
 */

`timescale 1ns/10ps

module analog_top #(
  parameter int NCH = 2  // number of analog channels
)(
  input  logic                           adc_clk,         // ADC sample clock
  input  logic                           rst_n_i,         // sync reset, active low
  input  analog_pkg::sample_t  [NCH-1:0] adc_dat_i,       // raw ADC words
  input  analog_pkg::dac_src_t [NCH-1:0] dac_src_i,       // generator and controller
  input  logic                           digital_loop_i,  // DAC to scope loopback
  output analog_pkg::sample_t  [NCH-1:0] scope_dat_o,     // acquisition data
  output analog_pkg::sample_t  [NCH-1:0] dac_dat_o,       // DAC pin words
  output logic                           dac_reset_o      // DAC reset
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  analog_pkg::sample_t   [NCH-1:0] adc_word;  // cleaned, channel order
  analog_pkg::chan_out_t [NCH-1:0] chan;      // channel results

  //////////////////////////////////////////////////
  // ADC capture
  //////////////////////////////////////////////////

  adc_capture #(
    .NCH (NCH)
  ) u_adc_capture (
    .adc_clk    (adc_clk  ),
    .rst_n_i    (rst_n_i  ),
    .adc_dat_i  (adc_dat_i),
    .adc_word_o (adc_word )
  );

  //////////////////////////////////////////////////
  // channels
  //////////////////////////////////////////////////

  generate
    for (genvar k = 0; k < NCH; k++)
    begin : g_chan
      analog_channel u_chan (
        .adc_clk        (adc_clk       ),
        .rst_n_i        (rst_n_i       ),
        .adc_word_i     (adc_word[k]   ),
        .dac_src_i      (dac_src_i[k]  ),
        .digital_loop_i (digital_loop_i),  // one level for all channels
        .chan_o         (chan[k]       )
      );

      // scope side sees the channel in its own order
      assign scope_dat_o[k] = chan[k].scope;
    end
  endgenerate

  //////////////////////////////////////////////////
  // DAC output
  //////////////////////////////////////////////////

  dac_output #(
    .NCH (NCH)
  ) u_dac_output (
    .adc_clk     (adc_clk    ),
    .rst_n_i     (rst_n_i    ),
    .chan_i      (chan       ),
    .dac_dat_o   (dac_dat_o  ),
    .dac_reset_o (dac_reset_o)
  );

endmodule : analog_top

//--- design/dac_output.sv
/*
 * DAC output register stage
 * crosses channel order onto the DAC pins and drives the DAC reset
 */

`timescale 1ns/10ps

module dac_output #(
  parameter int NCH = 2  // number of DAC channels
)(
  input  logic                            adc_clk,      // ADC sample clock
  input  logic                            rst_n_i,      // sync reset, active low
  input  analog_pkg::chan_out_t [NCH-1:0] chan_i,       // per-channel results
  output analog_pkg::sample_t   [NCH-1:0] dac_dat_o,    // DAC pin words
  output logic                            dac_reset_o   // DAC reset, active high
);

  //////////////////////////////////////////////////
  // channel crossing
  //////////////////////////////////////////////////

  // DAC codes in pin order
  analog_pkg::sample_t [NCH-1:0] dac_sw;

  // pins are crossed like the ADC side, ch_b -> dac_a
  always_comb
  begin
    for (int k = 0; k < NCH; k++)
    begin
      dac_sw[k] = chan_i[NCH-1-k].dac;
    end
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_dat_o <= '0;  // zero code until new samples arrive
    end
    else
    begin
      dac_dat_o <= dac_sw;
    end
  end

  //////////////////////////////////////////////////
  // DAC reset
  //////////////////////////////////////////////////

  // follows the fabric reset one cycle late
  // released one edge after rst_n_i goes high
  always_ff @(posedge adc_clk)
  begin
    dac_reset_o <= ~rst_n_i;
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // the DAC must be held in reset right behind the fabric
  // with its pins parked at the zero code
  dac_rst_a : assert property (
    @(posedge adc_clk)
    !rst_n_i |=> (dac_reset_o && dac_dat_o == '0)
  );

endmodule : dac_output

//--- design/analog_channel.sv
/*
 * one analog channel
 * generator plus controller sum, clamp and DAC inversion
 * digital loopback select for the scope data
 */

`timescale 1ns/10ps

module analog_channel (
  input  logic                  adc_clk,         // ADC sample clock
  input  logic                  rst_n_i,         // sync reset, active low
  input  analog_pkg::sample_t   adc_word_i,      // cleaned ADC word
  input  analog_pkg::dac_src_t  dac_src_i,       // generator and controller
  input  logic                  digital_loop_i,  // scope sees DAC code
  output analog_pkg::chan_out_t chan_o           // registered scope and dac
);

  //////////////////////////////////////////////////
  // local constants
  //////////////////////////////////////////////////

  localparam int W  = analog_pkg::SAMPLE_W;
  localparam int SW = analog_pkg::SUM_W;

  // sample range limits, 8191 and -8192 for 14 bits
  localparam analog_pkg::sample_t SAT_MAX = {1'b0, {(W-1){1'b1}}};
  localparam analog_pkg::sample_t SAT_MIN = {1'b1, {(W-1){1'b0}}};

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  logic signed [SW-1:0] sum;       // full width sum, never wraps
  logic                 ovf;       // sum left the sample range
  analog_pkg::sample_t  sat;       // clamped sum
  analog_pkg::sample_t  dac_code;  // inverted for the DAC

  //////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////

  // both operands sign extended to the guard width
  assign sum = SW'(dac_src_i.asg) + SW'(dac_src_i.pid);

  // top two bits differ only when the sum is out of range
  assign ovf = sum[SW-1] ^ sum[SW-2];

  always_comb
  begin
    if (ovf)
    begin
      sat = sum[SW-1] ? SAT_MIN : SAT_MAX;  // clamp toward the sign
    end
    else
    begin
      sat = sum[W-1:0];  // in range, plain truncation is exact
    end
  end

  // the DAC has a negative slope, so every bit flips
  assign dac_code = ~sat;

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      chan_o <= '0;
    end
    else
    begin
      chan_o.dac <= dac_code;
      // loopback takes the code of this same cycle
      // so scope and dac line up exactly
      if (digital_loop_i)
      begin
        chan_o.scope <= dac_code;
      end
      else
      begin
        chan_o.scope <= adc_word_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // after an overflow the registered code must be the clamped one,
  // never the inverse of the wrapped low bits
  dac_sat_a : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    ovf |=> (chan_o.dac != $past(~sum[W-1:0]))
  );

endmodule : analog_channel

//--- design/adc_capture.sv
/*
 * ADC input register stage
 * clears the noisy LSBs and crosses channel order toward the channels
 */

`timescale 1ns/10ps

module adc_capture #(
  parameter int NCH = 2  // number of ADC channels
)(
  input  logic                          adc_clk,     // ADC sample clock
  input  logic                          rst_n_i,     // sync reset, active low
  input  analog_pkg::sample_t [NCH-1:0] adc_dat_i,   // raw parallel ADC words
  output analog_pkg::sample_t [NCH-1:0] adc_word_o   // cleaned, reversed words
);

  //////////////////////////////////////////////////
  // local constants
  //////////////////////////////////////////////////

  localparam int W    = analog_pkg::SAMPLE_W;  // word width
  localparam int DROP = analog_pkg::ADC_DROP;  // cleared low bits

  // word after LSB clearing, still in pad order
  analog_pkg::sample_t [NCH-1:0] adc_clr;

  // word in channel order, ready for the register
  analog_pkg::sample_t [NCH-1:0] adc_sw;

  //////////////////////////////////////////////////
  // LSB clearing
  //////////////////////////////////////////////////

  // bottom bits only carry converter noise
  always_comb
  begin
    for (int i = 0; i < NCH; i++)
    begin
      adc_clr[i] = {adc_dat_i[i][W-1:DROP], {DROP{1'b0}}};
    end
  end

  //////////////////////////////////////////////////
  // channel crossing
  //////////////////////////////////////////////////

  // pads are wired in reverse, so channel k reads pad NCH-1-k
  always_comb
  begin
    for (int k = 0; k < NCH; k++)
    begin
      adc_sw[k] = adc_clr[NCH-1-k];  // adc_b -> ch_a and so on
    end
  end

  //////////////////////////////////////////////////
  // input register
  //////////////////////////////////////////////////

  // stands in for the pad input flops
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      adc_word_o <= '0;  // quiet input after reset
    end
    else
    begin
      adc_word_o <= adc_sw;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // the channels must never see X from the pads after reset
  adc_known_a : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    !$isunknown(adc_word_o)
  );

endmodule : adc_capture

//--- design/analog_pkg.sv
/*
 * shared widths and types of the analog data path
 * sample type, DAC source pair and per-channel result structs
 */

package analog_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // ADC, generator, controller and DAC words are all this wide
  localparam int SAMPLE_W = 14;

  // low ADC bits that carry only noise and are cleared
  localparam int ADC_DROP = 2;

  // one guard bit, enough for the sum of two samples
  localparam int SUM_W = SAMPLE_W + 1;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  // two's complement sample, one word
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // what a channel adds up for its DAC
  typedef struct packed
  {
    sample_t asg;  // arbitrary generator sample
    sample_t pid;  // controller sample
  } dac_src_t;

  // per-channel results, one cycle behind the inputs
  typedef struct packed
  {
    sample_t scope;  // acquisition data, ADC word or loopback code
    sample_t dac;    // inverted code for the neg-slope DAC
  } chan_out_t;

  // the scope field and the dac field have the same width, which
  // lets the loopback select pick either without any resizing
  // the DAC code always goes through saturation first
  // so the inversion never sees a wrapped sum

endpackage : analog_pkg
